/* aes_datapath/aes_round_func.sv */
`timescale 1ns/1ps
`default_nettype none

module aes_round_func
  import aes_pkg::*;
(
  input  aes_block_t state,
  input  aes_block_t round_key,
  input  logic       final_round,
  output aes_block_t round_out
);

  // ----------------------------------------------------------------------
  // GF(2^8) helpers
  // ----------------------------------------------------------------------

  // xtime, shift left and reduce when the top bit falls out
  function automatic logic [7:0] gm2(input logic [7:0] op);
    gm2 = {op[6:0], 1'b0} ^ (AES_GF_POLY & {8{op[7]}});
  endfunction

  function automatic logic [7:0] gm3(input logic [7:0] op);
    gm3 = gm2(op) ^ op;
  endfunction

  // one column times the fixed 02 03 01 01 circulant
  function automatic aes_word_t mix_column(input aes_word_t w);
    logic [7:0] a0;
    logic [7:0] a1;
    logic [7:0] a2;
    logic [7:0] a3;
    a0 = w[31:24];
    a1 = w[23:16];
    a2 = w[15:8];
    a3 = w[7:0];
    mix_column[31:24] = gm2(a0) ^ gm3(a1) ^ a2      ^ a3;
    mix_column[23:16] = a0      ^ gm2(a1) ^ gm3(a2) ^ a3;
    mix_column[15:8]  = a0      ^ a1      ^ gm2(a2) ^ gm3(a3);
    mix_column[7:0]   = gm3(a0) ^ a1      ^ a2      ^ gm2(a3);
  endfunction

  // ----------------------------------------------------------------------
  // round body
  // ----------------------------------------------------------------------

  aes_block_t shifted;
  aes_block_t mixed;

  // ShiftRows: row r of column c comes from column c+r
  // byte 0 of a word is row 0
  always_comb
  begin
    for (int c = 0; c < AES_NUM_WORDS; c++)
    begin
      for (int r = 0; r < 4; r++)
      begin
        shifted[c][8*(3-r) +: 8] = state[(c + r) % AES_NUM_WORDS][8*(3-r) +: 8];
      end
    end
  end

  // MixColumns is skipped in round 10
  always_comb
  begin
    for (int c = 0; c < AES_NUM_WORDS; c++)
    begin
      mixed[c] = final_round ? shifted[c] : mix_column(shifted[c]);
    end
  end

  // AddRoundKey
  assign round_out = mixed ^ round_key;

endmodule

`default_nettype wire

/* aes_datapath/aes_sbox_word.sv */
`timescale 1ns/1ps
`default_nettype none

module aes_sbox_word
  import aes_pkg::*;
(
  input  aes_word_t word_in,
  output aes_word_t word_out
);

  // ----------------------------------------------------------------------
  // forward sbox
  // ----------------------------------------------------------------------

  // constant ROM, entry 0 in the top byte
  // one line per high nibble of the input
  function automatic logic [7:0] sbox_byte(input logic [7:0] b);
    logic [0:255][7:0] sbox_tbl;
    sbox_tbl = {
      128'h637c777bf26b6fc53001672bfed7ab76,
      128'hca82c97dfa5947f0add4a2af9ca472c0,
      128'hb7fd9326363ff7cc34a5e5f171d83115,
      128'h04c723c31896059a071280e2eb27b275,
      128'h09832c1a1b6e5aa0523bd6b329e32f84,
      128'h53d100ed20fcb15b6acbbe394a4c58cf,
      128'hd0efaafb434d338545f9027f503c9fa8,
      128'h51a3408f929d38f5bcb6da2110fff3d2,
      128'hcd0c13ec5f974417c4a77e3d645d1973,
      128'h60814fdc222a908846eeb814de5e0bdb,
      128'he0323a0a4906245cc2d3ac629195e479,
      128'he7c8376d8dd54ea96c56f4ea657aae08,
      128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
      128'h703eb5664803f60e613557b986c11d9e,
      128'he1f8981169d98e949b1e87e9ce5528df,
      128'h8ca1890dbfe6426841992d0fb054bb16
    };
    sbox_byte = sbox_tbl[b];
  endfunction

  // ----------------------------------------------------------------------
  // four lookups in parallel
  // ----------------------------------------------------------------------

  // bytes of a column are independent, no ordering matters here
  always_comb
  begin
    for (int i = 0; i < 4; i++)
    begin
      word_out[8*i +: 8] = sbox_byte(word_in[8*i +: 8]);
    end
  end

endmodule

`default_nettype wire

/* aes_datapath/aes_state_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module aes_state_reg
  import aes_pkg::*;
(
  input  logic        clk,
  input  logic        reset_n,
  input  aes_update_t update,
  input  aes_block_t  block,
  input  aes_block_t  round_key,
  output aes_word_t   sbox_in,
  input  aes_word_t   sbox_out,
  input  aes_block_t  round_out,
  output aes_block_t  state
);

  // ----------------------------------------------------------------------
  // state words
  // ----------------------------------------------------------------------

  aes_block_t state_q;
  aes_block_t state_d;

  // column under substitution goes out to the sbox
  assign sbox_in = state_q[update.word_sel];

  // next value, picked by the command kind
  always_comb
  begin
    state_d = state_q;

    case (update.kind)
      // initial AddRoundKey with key 0
      UPD_INIT:
        state_d = block ^ round_key;

      // SubBytes, one column at a time
      UPD_SBOX:
        state_d[update.word_sel] = sbox_out;

      // rest of the round comes back from the round function
      UPD_MAIN, UPD_FINAL:
        state_d = round_out;

      // UPD_NONE holds the value, ciphertext stays put while idle
      default:
        state_d = state_q;
    endcase
  end

  // ----------------------------------------------------------------------
  // register
  // ----------------------------------------------------------------------

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state_q <= '0;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  assign state = state_q;

endmodule

`default_nettype wire

/* all.f */
common/aes_pkg.sv
aes_datapath/aes_sbox_word.sv
aes_datapath/aes_round_func.sv
aes_datapath/aes_state_reg.sv
rtl/aes_ctrl.sv
rtl/aes_encipher_top.sv
verif/aes_encipher_tb.sv

/* common/aes_pkg.sv */
`default_nettype none

package aes_pkg;

  // ----------------------------------------------------------------------
  // sizes fixed by AES-128
  // ----------------------------------------------------------------------

  // one state column
  localparam int AES_WORD_W = 32;

  // one block, also one round key
  localparam int AES_BLOCK_W = 128;

  // columns per block
  localparam int AES_NUM_WORDS = AES_BLOCK_W / AES_WORD_W;

  // last round index, the final round runs when the counter holds this value
  localparam logic [3:0] AES_NUM_ROUNDS = 4'd10;

  // x^8 reduction term for xtime
  localparam logic [7:0] AES_GF_POLY = 8'h1b;

  // ----------------------------------------------------------------------
  // data types
  // ----------------------------------------------------------------------

  typedef logic [AES_WORD_W-1:0] aes_word_t;

  // index 0 sits in the top bits, same order as the byte stream
  typedef aes_word_t [0:AES_NUM_WORDS-1] aes_block_t;

  // 0 = initial key add, 1..10 = rounds
  typedef logic [3:0] aes_round_t;

  // column picked for the current sbox pass
  typedef logic [1:0] aes_word_sel_t;

  // ----------------------------------------------------------------------
  // control encodings
  // ----------------------------------------------------------------------

  // kind of write the state register takes this cycle
  typedef enum logic [2:0] {
    UPD_NONE,
    UPD_INIT,
    UPD_SBOX,
    UPD_MAIN,
    UPD_FINAL
  } aes_update_e;

  // round FSM
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_INIT,
    ST_SBOX,
    ST_MAIN,
    ST_FINAL
  } aes_ctrl_state_e;

  // command from the control block to the state register
  typedef struct packed {
    aes_update_e   kind;
    aes_word_sel_t word_sel;
  } aes_update_t;

endpackage

`default_nettype wire

/* rtl/aes_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module aes_ctrl
  import aes_pkg::*;
(
  input  logic        clk,
  input  logic        reset_n,
  input  logic        next,
  output aes_update_t update,
  output aes_round_t  round,
  output logic        ready
);

  // ----------------------------------------------------------------------
  // registers
  // ----------------------------------------------------------------------

  aes_ctrl_state_e state_q;
  aes_ctrl_state_e state_d;

  // which column the sbox pass is on
  aes_word_sel_t   word_ctr_q;
  aes_word_sel_t   word_ctr_d;

  // round index, also selects the round key outside
  aes_round_t      round_q;
  aes_round_t      round_d;

  logic            ready_q;
  logic            ready_d;

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state_q    <= ST_IDLE;
      word_ctr_q <= '0;
      round_q    <= '0;
      ready_q    <= 1'b1;
    end
    else
    begin
      state_q    <= state_d;
      word_ctr_q <= word_ctr_d;
      round_q    <= round_d;
      ready_q    <= ready_d;
    end
  end

  // ----------------------------------------------------------------------
  // round FSM
  // ----------------------------------------------------------------------

  // one command per cycle, 51 edges from the start edge to ready
  always_comb
  begin
    state_d         = state_q;
    word_ctr_d      = word_ctr_q;
    round_d         = round_q;
    ready_d         = ready_q;
    update.kind     = UPD_NONE;
    update.word_sel = word_ctr_q;

    case (state_q)
      ST_IDLE:
      begin
        // key 0 has to be on round_key during INIT
        if (next)
        begin
          round_d = '0;
          ready_d = 1'b0;
          state_d = ST_INIT;
        end
      end

      ST_INIT:
      begin
        // block ^ key 0, then on to round 1
        update.kind = UPD_INIT;
        word_ctr_d  = '0;
        round_d     = round_q + 4'd1;
        state_d     = ST_SBOX;
      end

      ST_SBOX:
      begin
        update.kind = UPD_SBOX;
        // counter wraps to 0 after column 3, ready for the next pass
        word_ctr_d  = word_ctr_q + 2'd1;
        if (word_ctr_q == 2'd3)
        begin
          if (round_q == AES_NUM_ROUNDS)
            state_d = ST_FINAL;
          else
            state_d = ST_MAIN;
        end
      end

      ST_MAIN:
      begin
        update.kind = UPD_MAIN;
        round_d     = round_q + 4'd1;
        state_d     = ST_SBOX;
      end

      ST_FINAL:
      begin
        // round stays at 10 until the next start
        update.kind = UPD_FINAL;
        ready_d     = 1'b1;
        state_d     = ST_IDLE;
      end

      default:
      begin
        state_d = ST_IDLE;
      end
    endcase
  end

  assign round = round_q;
  assign ready = ready_q;

endmodule

`default_nettype wire

/* rtl/aes_encipher_top.sv */
`timescale 1ns/1ps
`default_nettype none

module aes_encipher_top
  import aes_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  logic       next,
  input  aes_block_t block,
  output aes_round_t round,
  input  aes_block_t round_key,
  output aes_block_t new_block,
  output logic       ready
);

  // ----------------------------------------------------------------------
  // internal wires
  // ----------------------------------------------------------------------

  // per-cycle command from the FSM
  aes_update_t update;

  // sbox word path
  aes_word_t   sbox_in;
  aes_word_t   sbox_out;

  // full round path
  aes_block_t  cur_state;
  aes_block_t  round_out;
  logic        final_round;

  // last round drops MixColumns, decoded once here from the command
  assign final_round = (update.kind == UPD_FINAL);

  // ciphertext is simply the state register once ready is back
  assign new_block = cur_state;

  // ----------------------------------------------------------------------
  // control
  // ----------------------------------------------------------------------

  aes_ctrl i_aes_ctrl (
    .clk     (clk),
    .reset_n (reset_n),
    .next    (next),
    .update  (update),
    .round   (round),
    .ready   (ready)
  );

  // ----------------------------------------------------------------------
  // datapath
  // ----------------------------------------------------------------------

  aes_state_reg i_aes_state_reg (
    .clk       (clk),
    .reset_n   (reset_n),
    .update    (update),
    .block     (block),
    .round_key (round_key),
    .sbox_in   (sbox_in),
    .sbox_out  (sbox_out),
    .round_out (round_out),
    .state     (cur_state)
  );

  // one column per cycle through the sbox
  aes_sbox_word i_aes_sbox_word (
    .word_in  (sbox_in),
    .word_out (sbox_out)
  );

  // ShiftRows, MixColumns and key add in one cycle
  aes_round_func i_aes_round_func (
    .state       (cur_state),
    .round_key   (round_key),
    .final_round (final_round),
    .round_out   (round_out)
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the AES-128 encipher testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/aes_sim

verilator --binary --timing -Wno-fatal \
  -f all.f \
  --top-module aes_encipher_tb \
  --Mdir obj_dir \
  -o aes_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./${BIN}" > "${LOG}" 2>&1
status=$?
cat "${LOG}"
if [ ${status} -ne 0 ]; then
  echo "simulation exited with status ${status}"
  exit 1
fi

if grep -qx "ALL TESTS PASSED" "${LOG}"; then
  exit 0
fi

echo "pass message not found in ${LOG}"
exit 1

/* verif/aes_encipher_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module aes_encipher_tb
  import aes_pkg::*;
();

  // ----------------------------------------------------------------------
  // trace layout and limits
  // ----------------------------------------------------------------------

  // per vector keys 0..10 come first, then plaintext and ciphertext
  localparam int LINES_PER_VEC   = 13;
  localparam int NUM_VECS        = 2;
  localparam int PT_OFS          = 11;
  localparam int CT_OFS          = 12;
  localparam int READY_LIMIT     = 200;
  // start edge to ready high as fixed by the round loop
  localparam int EXP_LATENCY     = 51;
  // four sbox edges and one main or final edge per round
  localparam int EDGES_PER_ROUND = 5;

  logic         clk;
  logic         reset_n;
  logic         next;
  aes_block_t   block;
  aes_round_t   round;
  aes_block_t   round_key;
  aes_block_t   new_block;
  logic         ready;

  logic [127:0] trace_mem [0:NUM_VECS*LINES_PER_VEC-1];
  int           cur_vec;
  integer       seed;
  int           gap;

  // bookkeeping for the report
  string        test_name;
  int           test_errors;
  int           pass_count;
  int           fail_count;

  aes_encipher_top i_aes_encipher_top (
    .clk       (clk),
    .reset_n   (reset_n),
    .next      (next),
    .block     (block),
    .round     (round),
    .round_key (round_key),
    .new_block (new_block),
    .ready     (ready)
  );

  // 100 ns period
  always
  begin
    #50 clk = ~clk;
  end

  // key for the round the core shows in the same cycle
  always_comb
  begin
    if (round <= AES_NUM_ROUNDS)
      round_key = trace_mem[cur_vec*LINES_PER_VEC + int'(round)];
    else
      round_key = '0;
  end

  // ----------------------------------------------------------------------
  // reporting helpers
  // ----------------------------------------------------------------------

  task automatic open_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic close_test();
    if (test_errors == 0)
    begin
      pass_count++;
      $display("test %s: passed", test_name);
    end
    else
    begin
      fail_count++;
      $display("test %s: failed with %0d errors", test_name, test_errors);
    end
  endtask

  task automatic expect_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
    if (expected !== actual)
    begin
      test_errors++;
      $display("CHECK FAILED [%s] %s: expected %0d, actual %0d",
               test_name, what, expected, actual);
    end
  endtask

  task automatic verify_block(input string what, input logic [127:0] expected,
                              input logic [127:0] actual);
    if (expected !== actual)
    begin
      test_errors++;
      $display("CHECK FAILED [%s] %s: expected %h, actual %h",
               test_name, what, expected, actual);
    end
  endtask

  // round shown after edge n of an operation
  // INIT moves it to 1, every fifth edge after that adds one, 10 at most
  function automatic int round_after_edge(input int n);
    int r;
    r = 1 + (n - 1) / EDGES_PER_ROUND;
    if (r > AES_NUM_ROUNDS)
      r = AES_NUM_ROUNDS;
    return r;
  endfunction

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------

  // one full encipher entered and left at a falling edge
  // glitch_edge > 0 pulses next again while the core is busy
  task automatic run_block(input int vec, input int glitch_edge);
    int           edges;
    logic [127:0] expected;
    expected = trace_mem[vec*LINES_PER_VEC + CT_OFS];
    edges    = 0;
    @(posedge clk);
    #1;
    cur_vec = vec;
    block   = trace_mem[vec*LINES_PER_VEC + PT_OFS];
    next    = 1'b1;
    // edge 0 samples next
    @(posedge clk);
    #1;
    next = 1'b0;
    @(negedge clk);
    expect_value("ready after start", 0, ready);
    expect_value("round during INIT", 0, round);
    while (ready !== 1'b1 && edges < READY_LIMIT)
    begin
      @(posedge clk);
      edges++;
      #1;
      next = (edges == glitch_edge);
      @(negedge clk);
      expect_value($sformatf("round after edge %0d", edges),
                   round_after_edge(edges), round);
    end
    if (ready !== 1'b1)
    begin
      $display("timeout in %s: ready never returned within %0d cycles",
               test_name, READY_LIMIT);
      $display("SOME TESTS FAILED");
      $finish;
    end
    else
    begin
      expect_value("edges from start to ready", EXP_LATENCY, edges);
      verify_block("ciphertext", expected, new_block);
    end
  endtask

  // idle cycles with next low where the result of vec must stay put
  task automatic hold_idle(input int vec, input int cycles);
    logic [127:0] expected;
    expected = trace_mem[vec*LINES_PER_VEC + CT_OFS];
    repeat (cycles)
    begin
      @(posedge clk);
      #1;
      next = 1'b0;
      @(negedge clk);
      expect_value("ready while idle", 1, ready);
      verify_block("held ciphertext", expected, new_block);
    end
  endtask

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------

  initial
  begin
    clk        = 1'b0;
    reset_n    = 1'b0;
    next       = 1'b0;
    block      = '0;
    cur_vec    = 0;
    seed       = 32'h81cb1a33;
    pass_count = 0;
    fail_count = 0;
    $readmemh("verif/aes_trace.txt", trace_mem);

    repeat (8) @(posedge clk);
    #1;
    reset_n = 1'b1;
    @(negedge clk);

    open_test("reset_state");
    expect_value("ready after reset", 1, ready);
    verify_block("new_block after reset", '0, new_block);
    close_test();

    // also covers the round sequence 0 and 1..10
    open_test("fips197_vector");
    run_block(0, 0);
    close_test();

    open_test("hold_result");
    hold_idle(0, 12);
    close_test();

    // random idle gap before a vector that shares nothing with the first
    open_test("zero_key_after_gap");
    gap = 3 + ($unsigned($random(seed)) % 20);
    hold_idle(0, gap);
    run_block(1, 0);
    close_test();

    // extra next pulse mid-operation and no restart afterwards
    open_test("next_ignored_while_busy");
    run_block(0, 17);
    hold_idle(0, 4);
    close_test();

    $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    if (fail_count == 0)
    begin
      $display("ALL TESTS PASSED");
    end
    else
    begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verif/aes_trace.txt */
// AES-128 trace, one 128-bit hex word per line
// per vector: round keys 0..10, then plaintext, then expected ciphertext
// vector 0: FIPS-197 appendix example
2b7e151628aed2a6abf7158809cf4f3c
a0fafe1788542cb123a339392a6c7605
f2c295f27a96b9435935807a7359f67f
3d80477d4716fe3e1e237e446d7a883b
ef44a541a8525b7fb671253bdb0bad00
d4d1c6f87c839d87caf2b8bc11f915bc
6d88a37a110b3efddbf98641ca0093fd
4e54f70e5f5fc9f384a64fb24ea6dc4f
ead27321b58dbad2312bf5607f8d292f
ac7766f319fadc2128d12941575c006e
d014f9a8c9ee2589e13f0cc8b6630ca6
3243f6a8885a308d313198a2e0370734
3925841d02dc09fbdc118597196a0b32
// vector 1: all-zero key, all-zero plaintext
00000000000000000000000000000000
62636363626363636263636362636363
9b9898c9f9fbfbaa9b9898c9f9fbfbaa
90973450696ccffaf2f457330b0fac99
ee06da7b876a1581759e42b27e91ee2b
7f2e2b88f8443e098dda7cbbf34b9290
ec614b851425758c99ff09376ab49ba7
217517873550620bacaf6b3cc61bf09b
0ef903333ba9613897060a04511dfa9f
b1d4d8e28a7db9da1d7bb3de4c664941
b4ef5bcb3e92e21123e951cf6f8f188e
00000000000000000000000000000000
66e94bd4ef8a2c3b884cfa59ca342b2e
